// ==== Bender.yml ====
package:
  name: tournament_predictor

sources:
  - files:
      - src/bp_pkg.sv
      - src/bp_update_if.sv
      - src/gshare_predictor.sv
      - src/bimodal_predictor.sv
      - src/tournament_chooser.sv
      - src/tournament_predictor.sv
  - target: simulation
    files:
      - tb/tb_tournament_predictor.sv

// ==== flist.f ====
src/bp_pkg.sv
src/bp_update_if.sv
src/gshare_predictor.sv
src/bimodal_predictor.sv
src/tournament_chooser.sv
src/tournament_predictor.sv
tb/tb_tournament_predictor.sv

// ==== src/bimodal_predictor.sv ====
`timescale 1ns/1ps

module bimodal_predictor import bp_pkg::*; #(
      parameter int ENTRIES    = 32,
      parameter int ADDR_WIDTH = 32
   )(
      input  logic            clk,
      input  logic            reset,
      input  logic [ADDR_WIDTH-1:0] predict_pc_i,
      input  logic            predict_branch_i,
      bp_update_if.sink       upd,
      output logic            bimodal_taken_o
   );

   localparam int INDEX_WIDTH = $clog2(ENTRIES);

   // PC indexed counter table
   ctr_state_e bht [ENTRIES];

   logic [INDEX_WIDTH-1:0] pred_idx;
   logic [INDEX_WIDTH-1:0] upd_idx;

   // ------------------------------
   // Index extraction
   assign pred_idx = predict_pc_i[PC_IDX_LSB +: INDEX_WIDTH];
   assign upd_idx  = upd.pc[PC_IDX_LSB +: INDEX_WIDTH];

   // Taken when counter upper bit set
   assign bimodal_taken_o = predict_branch_i & bht[pred_idx][1];

   // ------------------------------
   // Training, one entry per resolved branch
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < ENTRIES; i++) begin
            bht[i] <= WEAK_NT;
         end
      end else if (upd.valid) begin
         // Saturating step toward real outcome
         bht[upd_idx] <= ctr_step(bht[upd_idx], upd.taken);
      end
   end

   // An unknown PC would corrupt an arbitrary entry
   assert property (@(posedge clk) disable iff (!reset)
      upd.valid |-> !$isunknown(upd.pc))
      else $error("bimodal: unknown update PC");

endmodule

// ==== src/bp_pkg.sv ====
package bp_pkg;

   // ------------------------------
   // Direction counter, upper bit means taken
   typedef enum logic [1:0] {
      STRONG_NT = 2'b00,
      WEAK_NT   = 2'b01,
      WEAK_T    = 2'b10,
      STRONG_T  = 2'b11
   } ctr_state_e;

   // Chooser counter, upper bit selects gshare
   typedef enum logic [1:0] {
      STRONG_BIMODAL = 2'b00,
      WEAK_BIMODAL   = 2'b01,
      WEAK_GSHARE    = 2'b10,
      STRONG_GSHARE  = 2'b11
   } chooser_state_e;

   // Word aligned instructions, low two PC bits skipped
   localparam int PC_IDX_LSB = 2;

   // ------------------------------
   // Metadata word layout
   localparam int META_SEL_BIT = 0;
   localparam int META_BIM_BIT = 1;
   localparam int META_GSH_BIT = 2;
   localparam int META_GHR_LSB = 3;

   // One saturating step of a direction counter toward the outcome
   function automatic ctr_state_e ctr_step(input ctr_state_e s, input logic taken);
      case (s)
         STRONG_NT: return taken ? WEAK_NT  : STRONG_NT;
         WEAK_NT:   return taken ? WEAK_T   : STRONG_NT;
         WEAK_T:    return taken ? STRONG_T : WEAK_NT;
         default:   return taken ? STRONG_T : WEAK_T;
      endcase
   endfunction

endpackage

// ==== src/bp_update_if.sv ====
`timescale 1ns/1ps

// One resolved conditional branch, fanned out to all predictor parts
interface bp_update_if #(
      parameter int ADDR_WIDTH = 32,
      parameter int ENTRIES    = 32
   );

   localparam int INDEX_WIDTH = $clog2(ENTRIES);

   // Single cycle strobe per resolved branch
   logic                   valid;
   logic [ADDR_WIDTH-1:0]  pc;
   // Real outcome, not a mispredict flag
   logic                   taken;
   // Metadata returned from predict time
   logic [INDEX_WIDTH+2:0] meta;

   // Driver side, top level
   modport src (
      output valid, pc, taken, meta
   );

   // Readers, the three predictor parts
   modport sink (
      input valid, pc, taken, meta
   );

endinterface

// ==== src/gshare_predictor.sv ====
`timescale 1ns/1ps

module gshare_predictor import bp_pkg::*; #(
      parameter int ENTRIES    = 32,
      parameter int ADDR_WIDTH = 32
   )(
      input  logic            clk,
      input  logic            reset,
      input  logic [ADDR_WIDTH-1:0] predict_pc_i,
      input  logic            predict_branch_i,
      // Final tournament prediction, shifted into the history
      input  logic            final_taken_i,
      bp_update_if.sink       upd,
      output logic            gshare_taken_o,
      output logic [$clog2(ENTRIES)-1:0] ghr_o
   );

   localparam int INDEX_WIDTH = $clog2(ENTRIES);

   // Global history and pattern table
   logic [INDEX_WIDTH-1:0] ghr;
   ctr_state_e             pht [ENTRIES];

   // ------------------------------
   // Predict side
   logic [INDEX_WIDTH-1:0] pred_idx;

   // PC index hashed with current history
   assign pred_idx = predict_pc_i[PC_IDX_LSB +: INDEX_WIDTH] ^ ghr;

   // Upper counter bit, zero for non branches
   assign gshare_taken_o = predict_branch_i & pht[pred_idx][1];

   // History before this branch goes out in meta
   assign ghr_o = ghr;

   // ------------------------------
   // Update side decode
   logic [INDEX_WIDTH-1:0] upd_ghr;
   logic [INDEX_WIDTH-1:0] upd_idx;
   logic                   upd_final;
   logic                   restore;

   // History as it was when the branch was predicted
   assign upd_ghr = upd.meta[META_GHR_LSB +: INDEX_WIDTH];

   // Rebuild the same index used at predict time
   assign upd_idx = upd.pc[PC_IDX_LSB +: INDEX_WIDTH] ^ upd_ghr;

   // Final prediction the front end acted on
   assign upd_final = upd.meta[META_SEL_BIT] ? upd.meta[META_GSH_BIT]
                                             : upd.meta[META_BIM_BIT];

   // Wrong final prediction means speculative history is bad
   assign restore = upd.valid & (upd_final != upd.taken);

   // ------------------------------
   // History register
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         ghr <= '0;
      end else if (restore) begin
         // Repair wins over a same cycle speculative shift
         ghr <= {upd_ghr[INDEX_WIDTH-2:0], upd.taken};
      end else if (predict_branch_i) begin
         ghr <= {ghr[INDEX_WIDTH-2:0], final_taken_i};
      end
   end

   // Pattern table training on every resolved branch
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < ENTRIES; i++) begin
            pht[i] <= WEAK_NT;
         end
      end else if (upd.valid) begin
         pht[upd_idx] <= ctr_step(pht[upd_idx], upd.taken);
      end
   end

   // ------------------------------
   // Checks
   // Returned history must be clean or the index rebuild is garbage
   assert property (@(posedge clk) disable iff (!reset)
      upd.valid |-> !$isunknown(upd.meta[META_GHR_LSB +: INDEX_WIDTH]))
      else $error("gshare: unknown history in update meta");

   // History stays known across shifts and restores
   assert property (@(posedge clk) disable iff (!reset)
      !$isunknown(ghr))
      else $error("gshare: global history went unknown");

endmodule

// ==== src/tournament_chooser.sv ====
`timescale 1ns/1ps

module tournament_chooser import bp_pkg::*; #(
      parameter int ENTRIES    = 32,
      parameter int ADDR_WIDTH = 32
   )(
      input  logic            clk,
      input  logic            reset,
      input  logic [ADDR_WIDTH-1:0] predict_pc_i,
      input  logic            predict_branch_i,
      input  logic            gshare_taken_i,
      input  logic            bimodal_taken_i,
      input  logic [$clog2(ENTRIES)-1:0] ghr_i,
      bp_update_if.sink       upd,
      output logic            branch_taken_o,
      output logic [$clog2(ENTRIES)+2:0] meta_o
   );

   localparam int INDEX_WIDTH = $clog2(ENTRIES);

   // Chooser counters
   chooser_state_e chooser_table [ENTRIES];

   // Step one position toward gshare or toward bimodal
   function automatic chooser_state_e chooser_step(input chooser_state_e s,
                                                   input logic to_gshare);
      case (s)
         STRONG_BIMODAL: return to_gshare ? WEAK_BIMODAL  : STRONG_BIMODAL;
         WEAK_BIMODAL:   return to_gshare ? WEAK_GSHARE   : STRONG_BIMODAL;
         WEAK_GSHARE:    return to_gshare ? STRONG_GSHARE : WEAK_BIMODAL;
         default:        return to_gshare ? STRONG_GSHARE : WEAK_GSHARE;
      endcase
   endfunction

   // ------------------------------
   // Predict side
   logic [INDEX_WIDTH-1:0] pred_idx;
   logic                   sel;

   assign pred_idx = predict_pc_i[PC_IDX_LSB +: INDEX_WIDTH];

   // 1 picks gshare, 0 picks bimodal
   assign sel = chooser_table[pred_idx][1];

   assign branch_taken_o = predict_branch_i & (sel ? gshare_taken_i : bimodal_taken_i);

   // Pack everything the update path needs later
   always_comb begin
      meta_o                                = '0;
      meta_o[META_GHR_LSB +: INDEX_WIDTH]   = ghr_i;
      meta_o[META_GSH_BIT]                  = gshare_taken_i;
      meta_o[META_BIM_BIT]                  = bimodal_taken_i;
      meta_o[META_SEL_BIT]                  = sel;
   end

   // ------------------------------
   // Update side
   logic [INDEX_WIDTH-1:0] upd_idx;
   logic                   disagree;
   logic                   gsh_right;
   logic                   train_en;
   chooser_state_e         chooser_cur;
   chooser_state_e         chooser_next;

   assign upd_idx   = upd.pc[PC_IDX_LSB +: INDEX_WIDTH];
   assign disagree  = upd.meta[META_GSH_BIT] != upd.meta[META_BIM_BIT];
   // With a disagreement exactly one side matched
   assign gsh_right = upd.meta[META_GSH_BIT] == upd.taken;

   // Only disagreements teach the chooser anything
   assign train_en     = upd.valid & disagree;
   assign chooser_cur  = chooser_table[upd_idx];
   assign chooser_next = chooser_step(chooser_cur, gsh_right);

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < ENTRIES; i++) begin
            chooser_table[i] <= WEAK_BIMODAL;
         end
      end else if (train_en) begin
         chooser_table[upd_idx] <= chooser_next;
      end
   end

   // Written value only moves toward the side that matched, so it never wraps
   assert property (@(posedge clk) disable iff (!reset)
      train_en |-> (gsh_right ? (chooser_next >= chooser_cur)
                              : (chooser_next <= chooser_cur)))
      else $error("chooser: counter stepped past saturation");

endmodule

// ==== src/tournament_predictor.sv ====
`timescale 1ns/1ps

module tournament_predictor #(
      parameter  int ENTRIES     = 32,
      parameter  int ADDR_WIDTH  = 32,
      localparam int INDEX_WIDTH = $clog2(ENTRIES)
   )(
      input  logic                   clk,
      input  logic                   reset,

      // ------------------------------
      // Predict port
      input  logic [ADDR_WIDTH-1:0]  predict_pc_i,
      input  logic                   predict_branch_i,
      output logic                   branch_taken_o,
      output logic [INDEX_WIDTH+2:0] meta_o,

      // ------------------------------
      // Resolve port
      input  logic                   update_valid_i,
      input  logic [ADDR_WIDTH-1:0]  update_pc_i,
      input  logic                   update_taken_i,
      input  logic [INDEX_WIDTH+2:0] update_meta_i
   );

   // Component predictions and history into the chooser
   logic                   gshare_taken;
   logic                   bimodal_taken;
   logic [INDEX_WIDTH-1:0] ghr;

   // Shared resolve bus
   bp_update_if #(.ADDR_WIDTH(ADDR_WIDTH), .ENTRIES(ENTRIES)) upd_if ();

   assign upd_if.valid = update_valid_i;
   assign upd_if.pc    = update_pc_i;
   assign upd_if.taken = update_taken_i;
   assign upd_if.meta  = update_meta_i;

   // History fed back from the final prediction
   gshare_predictor #(.ENTRIES(ENTRIES), .ADDR_WIDTH(ADDR_WIDTH)) gshare_i (
      .clk              (clk),
      .reset            (reset),
      .predict_pc_i     (predict_pc_i),
      .predict_branch_i (predict_branch_i),
      .final_taken_i    (branch_taken_o),
      .upd              (upd_if),
      .gshare_taken_o   (gshare_taken),
      .ghr_o            (ghr)
   );

   bimodal_predictor #(.ENTRIES(ENTRIES), .ADDR_WIDTH(ADDR_WIDTH)) bimodal_i (
      .clk              (clk),
      .reset            (reset),
      .predict_pc_i     (predict_pc_i),
      .predict_branch_i (predict_branch_i),
      .upd              (upd_if),
      .bimodal_taken_o  (bimodal_taken)
   );

   // Final select and meta packing
   tournament_chooser #(.ENTRIES(ENTRIES), .ADDR_WIDTH(ADDR_WIDTH)) chooser_i (
      .clk              (clk),
      .reset            (reset),
      .predict_pc_i     (predict_pc_i),
      .predict_branch_i (predict_branch_i),
      .gshare_taken_i   (gshare_taken),
      .bimodal_taken_i  (bimodal_taken),
      .ghr_i            (ghr),
      .upd              (upd_if),
      .branch_taken_o   (branch_taken_o),
      .meta_o           (meta_o)
   );

endmodule

// ==== tb/tb_tournament_predictor.sv ====
`timescale 1ns/1ps

module tb_tournament_predictor import bp_pkg::*; ();

   localparam int ENTRIES        = 32;
   localparam int ADDR_WIDTH     = 32;
   localparam int IW             = $clog2(ENTRIES);
   localparam int MW             = IW + 3;
   localparam int RESET_CYCLES   = 5;
   localparam int RANDOM_CYCLES  = 2000;
   // Random phase plus a quarter for reset and the directed steps
   localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + RANDOM_CYCLES / 4;

   logic                  clk;
   logic                  reset;
   logic [ADDR_WIDTH-1:0] predict_pc;
   logic                  predict_branch;
   logic                  update_valid;
   logic [ADDR_WIDTH-1:0] update_pc;
   logic                  update_taken;
   logic [MW-1:0]         update_meta;
   logic                  branch_taken;
   logic [MW-1:0]         meta;

   // PC pool, pairs 0x1000/0x1080, 0x2010/0x2090 and 0x3ffc/0x1f7c alias
   logic [ADDR_WIDTH-1:0] pc_pool [8] = '{32'h0000_1000, 32'h0000_1004, 32'h0000_1008,
                                          32'h0000_1080, 32'h0000_2010, 32'h0000_2090,
                                          32'h0000_3ffc, 32'h0000_1f7c};
   // Taken when a 3 bit random value is below this, per pool slot
   int                    taken_thr [8] = '{8, 0, 7, 1, 4, 6, 2, 5};

   // ------------------------------
   // Reference model state
   logic [1:0]            m_pht [ENTRIES];
   logic [1:0]            m_bht [ENTRIES];
   logic [1:0]            m_cho [ENTRIES];
   logic [IW-1:0]         m_ghr;
   logic                  restore_pending;
   logic [IW-1:0]         restore_ghr;

   // Branches predicted but not yet resolved
   logic [ADDR_WIDTH-1:0] q_pc [$];
   logic [MW-1:0]         q_meta [$];

   logic [15:0]           lfsr = 16'd51;
   int                    check_count = 0;
   int                    error_count = 0;
   int                    cycle_count = 0;

   tournament_predictor #(.ENTRIES(ENTRIES), .ADDR_WIDTH(ADDR_WIDTH)) dut_i (
      .clk              (clk),
      .reset            (reset),
      .predict_pc_i     (predict_pc),
      .predict_branch_i (predict_branch),
      .branch_taken_o   (branch_taken),
      .meta_o           (meta),
      .update_valid_i   (update_valid),
      .update_pc_i      (update_pc),
      .update_taken_i   (update_taken),
      .update_meta_i    (update_meta)
   );

   // 100 ns period
   initial clk = 1'b0;
   always #50 clk = ~clk;

   // Hard stop if the run hangs
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   // ------------------------------
   // Helpers
   // 16 bit Galois LFSR, taps 16,14,13,11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 16'hB400;
      return n;
   endfunction

   // One LFSR step per bit
   task automatic take_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[6:0], lfsr[0]};
      end
   endtask

   // 2 bit saturating counter, up toward taken or toward gshare
   function automatic logic [1:0] saturate_step(input logic [1:0] c, input logic up);
      if (up)
         return (c == 2'd3) ? c : c + 2'd1;
      return (c == 2'd0) ? c : c - 2'd1;
   endfunction

   function automatic int slot_of(input logic [ADDR_WIDTH-1:0] pc);
      int s;
      s = 0;
      for (int i = 0; i < 8; i++) begin
         if (pc_pool[i] == pc)
            s = i;
      end
      return s;
   endfunction

   task automatic clear_model();
      for (int i = 0; i < ENTRIES; i++) begin
         m_pht[i] = WEAK_NT;
         m_bht[i] = WEAK_NT;
         m_cho[i] = WEAK_BIMODAL;
      end
      m_ghr           = '0;
      restore_pending = 1'b0;
      restore_ghr     = '0;
   endtask

   // ------------------------------
   // Drive one cycle, check at the falling edge, then advance the model
   task automatic run_cycle(input logic pb, input logic [ADDR_WIDTH-1:0] pc,
                            input logic uv, input logic [ADDR_WIDTH-1:0] upc,
                            input logic ut, input logic [MW-1:0] umeta);
      logic [IW-1:0] idx;
      logic [IW-1:0] u_idx;
      logic [IW-1:0] u_ghr;
      logic          gsh;
      logic          bim;
      logic          sel;
      logic          fin;
      logic          u_fin;
      logic [MW-1:0] exp_meta;
      @(posedge clk);
      #1;
      predict_branch = pb;
      predict_pc     = pc;
      update_valid   = uv;
      update_pc      = upc;
      update_taken   = ut;
      update_meta    = umeta;
      @(negedge clk);
      // Expected prediction from the model state before this edge
      idx      = pc[PC_IDX_LSB +: IW];
      gsh      = pb & m_pht[idx ^ m_ghr][1];
      bim      = pb & m_bht[idx][1];
      sel      = m_cho[idx][1];
      fin      = pb & (sel ? gsh : bim);
      exp_meta = '0;
      exp_meta[META_GHR_LSB +: IW] = m_ghr;
      exp_meta[META_GSH_BIT]       = gsh;
      exp_meta[META_BIM_BIT]       = bim;
      exp_meta[META_SEL_BIT]       = sel;
      check_count++;
      assert (branch_taken === fin) else begin
         error_count++;
         $display("Mismatch at %0t: branch_taken_o for pc %h is %b, model %b",
                  $time, pc, branch_taken, fin);
      end
      assert (meta === exp_meta) else begin
         error_count++;
         $display("Mismatch at %0t: meta_o for pc %h is %h, model %h",
                  $time, pc, meta, exp_meta);
      end
      // No branch, no taken prediction
      if (!pb)
         assert (branch_taken === 1'b0) else begin
            error_count++;
            $display("Mismatch at %0t: branch_taken_o high without a branch", $time);
         end
      // History repaired after last cycle's wrong final prediction
      if (restore_pending)
         assert (meta[META_GHR_LSB +: IW] === restore_ghr) else begin
            error_count++;
            $display("Mismatch at %0t: restored history is %h, expected %h",
                     $time, meta[META_GHR_LSB +: IW], restore_ghr);
         end
      if (pb) begin
         q_pc.push_back(pc);
         q_meta.push_back(exp_meta);
      end
      // Training, one write per table
      restore_pending = 1'b0;
      u_fin           = 1'b0;
      u_ghr           = '0;
      if (uv) begin
         u_ghr = umeta[META_GHR_LSB +: IW];
         u_idx = upc[PC_IDX_LSB +: IW];
         m_pht[u_idx ^ u_ghr] = saturate_step(m_pht[u_idx ^ u_ghr], ut);
         m_bht[u_idx]         = saturate_step(m_bht[u_idx], ut);
         // Chooser learns only from a disagreement
         if (umeta[META_GSH_BIT] != umeta[META_BIM_BIT])
            m_cho[u_idx] = saturate_step(m_cho[u_idx], umeta[META_GSH_BIT] == ut);
         u_fin = umeta[META_SEL_BIT] ? umeta[META_GSH_BIT] : umeta[META_BIM_BIT];
      end
      // Restore beats the speculative shift
      if (uv && (u_fin != ut)) begin
         m_ghr           = {u_ghr[IW-2:0], ut};
         restore_pending = 1'b1;
         restore_ghr     = m_ghr;
      end else if (pb) begin
         m_ghr = {m_ghr[IW-2:0], fin};
      end
   endtask

   // ------------------------------
   // Stimulus
   initial begin
      logic [7:0]            r;
      logic                  pb;
      logic                  uv;
      logic                  ut;
      logic [ADDR_WIDTH-1:0] pc;
      logic [ADDR_WIDTH-1:0] upc;
      logic [MW-1:0]         umeta;
      reset          = 1'b0;
      predict_pc     = '0;
      predict_branch = 1'b0;
      update_valid   = 1'b0;
      update_pc      = '0;
      update_taken   = 1'b0;
      update_meta    = '0;
      clear_model();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b1;

      // First branch after reset, all tables weak and history clear
      run_cycle(1'b1, pc_pool[0], 1'b0, '0, 1'b0, '0);
      assert (branch_taken === 1'b0 && meta === '0) else begin
         error_count++;
         $display("Mismatch at %0t: first prediction after reset is %b meta %h",
                  $time, branch_taken, meta);
      end

      // Random predict and resolve traffic
      for (int c = 0; c < RANDOM_CYCLES; c++) begin
         take_bits(1, r);
         pb = r[0];
         take_bits(3, r);
         pc = pc_pool[r[2:0]];
         take_bits(1, r);
         uv    = r[0] && (q_pc.size() > 0);
         upc   = '0;
         ut    = 1'b0;
         umeta = '0;
         if (uv) begin
            upc   = q_pc.pop_front();
            umeta = q_meta.pop_front();
            // Outcome biased by the branch's pool slot
            take_bits(3, r);
            ut = (r[2:0] < taken_thr[slot_of(upc)]);
         end
         run_cycle(pb, pc, uv, upc, ut, umeta);
      end

      // Saturate one PC taken, then a single not taken must not flip it
      repeat (6) run_cycle(1'b0, pc_pool[0], 1'b1, pc_pool[2], 1'b1, '0);
      run_cycle(1'b1, pc_pool[2], 1'b0, '0, 1'b0, '0);
      assert (meta[META_BIM_BIT] === 1'b1) else begin
         error_count++;
         $display("Mismatch at %0t: bimodal not taken after saturating updates", $time);
      end
      run_cycle(1'b0, pc_pool[0], 1'b1, pc_pool[2], 1'b0, '0);
      run_cycle(1'b1, pc_pool[2], 1'b0, '0, 1'b0, '0);
      assert (meta[META_BIM_BIT] === 1'b1) else begin
         error_count++;
         $display("Mismatch at %0t: one not taken update flipped a strong counter", $time);
      end

      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
